// ==== src/sd_pkg.sv ====
//####################################################################
// shared definitions for the sd host controller front end
// width typedefs, wishbone register offsets and cmd error codes
// cmd engine state encoding, sck/request/response/status structs
//####################################################################
package sd_pkg;

    typedef logic [7:0]  wb_addr_t;     // wishbone byte address
    typedef logic [31:0] wb_data_t;     // wishbone data word
    typedef logic [5:0]  sd_cmd_idx_t;  // command index
    typedef logic [31:0] sd_arg_t;      // cmd argument / resp payload
    typedef logic [6:0]  sd_crc7_t;     // crc7 over 40 frame bits
    typedef logic [3:0]  sd_err_t;      // cmd error code

    localparam sd_err_t SD_ERR_NONE    = 4'd0;
    localparam sd_err_t SD_ERR_TIMEOUT = 4'd1;  // no start bit within watchdog
    localparam sd_err_t SD_ERR_CRC     = 4'd2;
    localparam sd_err_t SD_ERR_STOP    = 4'd3;  // end bit sampled as 0

    typedef enum logic [3:0] {
        CMD_IDLE      = 4'd0,
        CMD_TX        = 4'd1,
        CMD_WAIT_RESP = 4'd2,
        CMD_RX        = 4'd3,
        CMD_DONE      = 4'd4
    } sd_cmd_state_e;

    localparam wb_addr_t REG_SCKDIV    = 8'h00;  // rw {data div, ident div}
    localparam wb_addr_t REG_CONTROL   = 8'h04;  // rw enable/clear/ident, ro pins
    localparam wb_addr_t REG_WATCHDOG  = 8'h08;  // rw
    localparam wb_addr_t REG_CMD_ARG   = 8'h0C;  // rw
    localparam wb_addr_t REG_STATUS    = 8'h10;  // ro
    localparam wb_addr_t REG_LAST_RESP = 8'h14;  // ro
    localparam wb_addr_t REG_RESP_ARG  = 8'h18;  // ro
    localparam wb_addr_t REG_CMD_START = 8'h1C;  // wo, index in [5:0]

    typedef struct packed {
        logic level;    // sd clock level
        logic pos_stb;  // one cycle before rising edge
        logic neg_stb;  // one cycle before falling edge
    } sd_sck_t;

    typedef struct packed {
        logic        start;
        sd_cmd_idx_t idx;
        sd_arg_t     arg;
    } sd_cmd_req_t;

    typedef struct packed {
        logic        done;
        sd_cmd_idx_t idx;
        sd_arg_t     arg;
        sd_crc7_t    crc_rx;
        sd_crc7_t    crc_calc;
    } sd_cmd_resp_t;

    typedef struct packed {
        sd_cmd_state_e state;
        sd_err_t       err;
        logic          busy;
    } sd_cmd_stat_t;

endpackage

// ==== src/sd_regs.sv ====
//####################################################################
// wishbone classic register slave of the sd host controller
// sd clock scaler with edge strobes, cmd start request,
// capture of the last request index and response for debug reads
//####################################################################
`timescale 1ns/1ps

module sd_regs import sd_pkg::*; #(
    parameter logic [15:0] WDOG_RESET    = 16'h0400,  // watchdog reset value
    parameter logic [7:0]  SCK_DIV_RESET = 8'd4       // data scaler reset value
) (
    input  logic         i_clk,
    input  logic         i_nrst,
    input  logic         i_wb_cyc,
    input  logic         i_wb_stb,
    input  logic         i_wb_we,
    input  wb_addr_t     i_wb_adr,
    input  wb_data_t     i_wb_dat,
    input  logic         i_sd_cmd,      // live cmd pin
    input  logic [3:0]   i_sd_dat,      // live dat pins
    input  sd_cmd_resp_t i_resp,
    input  sd_cmd_stat_t i_stat,
    output logic         o_wb_ack,
    output wb_data_t     o_wb_dat,
    output sd_sck_t      o_sck,
    output sd_cmd_req_t  o_req,
    output logic [15:0]  o_watchdog,
    output logic         o_clear_err
);

    localparam logic [23:0] IDENT_DIV_RESET = 24'd124;  // ~400 khz at 100 mhz

    logic         wb_sel;        // first cycle of a bus access
    logic         wb_wr;
    wb_data_t     rd_word;
    logic         ack_q;
    wb_data_t     rdat_q;
    logic         sclk_ena;
    logic         ident_sel;     // 1: ident scaler drives sck
    logic         clear_q;
    logic [7:0]   div_data;
    logic [23:0]  div_ident;
    logic [23:0]  scaler_cnt;
    logic [23:0]  scaler_cmp;
    logic         scaler_hit;
    logic         sck_level;
    logic [15:0]  wdog;
    sd_arg_t      cmd_arg;
    logic         start_q;
    sd_cmd_idx_t  last_req_idx;  // also the index of the running command
    sd_cmd_resp_t last_resp;

    assign wb_sel = i_wb_cyc & i_wb_stb & ~ack_q;  // ack cycle never restarts
    assign wb_wr  = wb_sel & i_wb_we;

    assign scaler_cmp = ident_sel ? div_ident : {16'd0, div_data};
    assign scaler_hit = sclk_ena & (scaler_cnt == scaler_cmp);

    always_comb begin
        rd_word = '0;  // unmapped and write-only offsets read zero
        case (i_wb_adr)
            REG_SCKDIV: begin
                rd_word = {div_data, div_ident};
            end
            REG_CONTROL: begin
                rd_word[0]   = sclk_ena;
                rd_word[2]   = ident_sel;
                rd_word[7:4] = i_sd_dat;
                rd_word[8]   = i_sd_cmd;
            end
            REG_WATCHDOG: begin
                rd_word[15:0] = wdog;
            end
            REG_CMD_ARG: begin
                rd_word = cmd_arg;
            end
            REG_STATUS: begin
                rd_word[3:0] = i_stat.err;
                rd_word[7:4] = i_stat.state;
                rd_word[8]   = i_stat.busy;
            end
            REG_LAST_RESP: begin
                rd_word[5:0]   = last_req_idx;
                rd_word[13:8]  = last_resp.idx;
                rd_word[22:16] = last_resp.crc_rx;
                rd_word[30:24] = last_resp.crc_calc;
            end
            REG_RESP_ARG: begin
                rd_word = last_resp.arg;
            end
            default: begin
                rd_word = '0;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_sel;  // exactly one cycle per access
        end
    end

    always_ff @(posedge i_clk) begin
        if (wb_sel) begin
            rdat_q <= rd_word;  // sampled with the ack
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            sclk_ena     <= 1'b0;
            ident_sel    <= 1'b0;
            clear_q      <= 1'b0;
            div_data     <= SCK_DIV_RESET;
            div_ident    <= IDENT_DIV_RESET;
            wdog         <= WDOG_RESET;
            cmd_arg      <= '0;
            start_q      <= 1'b0;
            last_req_idx <= '0;
        end else begin
            clear_q <= wb_wr & (i_wb_adr == REG_CONTROL) & i_wb_dat[1];
            start_q <= 1'b0;
            if (wb_wr) begin
                case (i_wb_adr)
                    REG_SCKDIV: begin
                        div_data  <= i_wb_dat[31:24];
                        div_ident <= i_wb_dat[23:0];
                    end
                    REG_CONTROL: begin
                        sclk_ena  <= i_wb_dat[0];
                        ident_sel <= i_wb_dat[2];
                    end
                    REG_WATCHDOG: wdog <= i_wb_dat[15:0];
                    REG_CMD_ARG:  cmd_arg <= i_wb_dat;
                    REG_CMD_START: begin
                        if (!i_stat.busy && !start_q) begin  // drop start while busy
                            start_q      <= 1'b1;
                            last_req_idx <= i_wb_dat[5:0];
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // sd clock scaler, count restarts on hit or on a divider write
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            scaler_cnt <= '0;
            sck_level  <= 1'b0;
        end else begin
            if (wb_wr && (i_wb_adr == REG_SCKDIV)) begin
                scaler_cnt <= '0;
            end else if (scaler_hit) begin
                scaler_cnt <= '0;
            end else if (sclk_ena) begin
                scaler_cnt <= scaler_cnt + 24'd1;
            end
            if (scaler_hit) begin
                sck_level <= ~sck_level;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_resp.done) begin
            last_resp <= i_resp;  // debug copy of the finished response
        end
    end

    assign o_wb_ack      = ack_q;
    assign o_wb_dat      = rdat_q;
    assign o_sck.level   = sck_level;
    assign o_sck.pos_stb = scaler_hit & ~sck_level;  // level is about to rise
    assign o_sck.neg_stb = scaler_hit & sck_level;
    assign o_req.start   = start_q;
    assign o_req.idx     = last_req_idx;
    assign o_req.arg     = cmd_arg;
    assign o_watchdog    = wdog;
    assign o_clear_err   = clear_q;

endmodule

// ==== src/sd_cmd_ctrl.sv ====
//####################################################################
// sd cmd line engine
// sends a 48-bit command frame with crc7 on sck falling edges,
// waits for the response start bit under a watchdog, then samples
// and checks a 48-bit r1 response; keeps a sticky error code
//####################################################################
`timescale 1ns/1ps

module sd_cmd_ctrl import sd_pkg::*; (
    input  logic         i_clk,
    input  logic         i_nrst,
    input  sd_sck_t      i_sck,
    input  sd_cmd_req_t  i_req,
    input  logic [15:0]  i_watchdog,   // sck periods to wait for a response
    input  logic         i_clear_err,
    input  logic         i_sd_cmd,
    output logic         o_sd_cmd,
    output logic         o_sd_cmd_oe,
    output sd_cmd_resp_t o_resp,
    output sd_cmd_stat_t o_stat
);

    sd_cmd_state_e state;
    logic [47:0]   shreg;      // tx frame out of [47], rx bits into [0]
    logic [5:0]    bit_cnt;
    sd_crc7_t      crc;
    logic [15:0]   wdog_cnt;
    logic          tmo;        // watchdog expired for this command
    sd_err_t       err;        // sticky until cleared
    logic          cmd_q;
    logic          oe_q;
    logic          tx_in_crc;
    logic          tx_bit;
    sd_err_t       result;

    // serial crc7, polynomial x^7 + x^3 + 1
    function automatic sd_crc7_t crc7_step(sd_crc7_t c, logic b);
        logic fb;
        fb = b ^ c[6];
        return {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    endfunction

    assign tx_in_crc = (bit_cnt >= 6'd40) && (bit_cnt < 6'd47);
    assign tx_bit    = tx_in_crc ? crc[6] : shreg[47];  // crc shifted out msb first

    always_comb begin
        if (tmo) begin
            result = SD_ERR_TIMEOUT;
        end else if (shreg[7:1] != crc) begin
            result = SD_ERR_CRC;
        end else if (!shreg[0]) begin
            result = SD_ERR_STOP;
        end else begin
            result = SD_ERR_NONE;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state    <= CMD_IDLE;
            shreg    <= '0;
            bit_cnt  <= '0;
            crc      <= '0;
            wdog_cnt <= '0;
            tmo      <= 1'b0;
            err      <= SD_ERR_NONE;
            cmd_q    <= 1'b1;
            oe_q     <= 1'b0;
        end else begin
            if (i_clear_err) begin
                err <= SD_ERR_NONE;
            end
            case (state)
                CMD_IDLE: begin
                    if (i_req.start) begin
                        // start 0, transmitter 1, index, arg, crc slot, end 1
                        shreg   <= {2'b01, i_req.idx, i_req.arg, 7'd0, 1'b1};
                        bit_cnt <= '0;
                        crc     <= '0;
                        tmo     <= 1'b0;
                        state   <= CMD_TX;
                    end
                end
                CMD_TX: begin
                    if (i_sck.neg_stb) begin
                        if (bit_cnt == 6'd48) begin
                            oe_q     <= 1'b0;  // release line after end bit
                            cmd_q    <= 1'b1;
                            wdog_cnt <= '0;
                            state    <= CMD_WAIT_RESP;
                        end else begin
                            oe_q    <= 1'b1;
                            cmd_q   <= tx_bit;
                            shreg   <= {shreg[46:0], 1'b0};
                            bit_cnt <= bit_cnt + 6'd1;
                            if (bit_cnt < 6'd40) begin
                                crc <= crc7_step(crc, tx_bit);
                            end else if (tx_in_crc) begin
                                crc <= {crc[5:0], 1'b0};
                            end
                        end
                    end
                end
                CMD_WAIT_RESP: begin
                    if (i_sck.pos_stb) begin
                        if (!i_sd_cmd) begin
                            shreg   <= {shreg[46:0], 1'b0};  // start bit
                            crc     <= '0;                   // crc of a single 0 bit
                            bit_cnt <= 6'd1;
                            state   <= CMD_RX;
                        end else if (wdog_cnt == i_watchdog) begin
                            tmo   <= 1'b1;
                            state <= CMD_DONE;
                        end else begin
                            wdog_cnt <= wdog_cnt + 16'd1;
                        end
                    end
                end
                CMD_RX: begin
                    if (i_sck.pos_stb) begin
                        shreg   <= {shreg[46:0], i_sd_cmd};
                        bit_cnt <= bit_cnt + 6'd1;
                        if (bit_cnt < 6'd40) begin
                            crc <= crc7_step(crc, i_sd_cmd);
                        end
                        if (bit_cnt == 6'd47) begin  // end bit sampled
                            state <= CMD_DONE;
                        end
                    end
                end
                CMD_DONE: begin
                    if (result != SD_ERR_NONE) begin
                        err <= result;  // a new error wins over a same-cycle clear
                    end
                    state <= CMD_IDLE;
                end
                default: state <= CMD_IDLE;
            endcase
        end
    end

    assign o_sd_cmd        = cmd_q;
    assign o_sd_cmd_oe     = oe_q;
    assign o_resp.done     = (state == CMD_DONE);
    assign o_resp.idx      = shreg[45:40];
    assign o_resp.arg      = shreg[39:8];
    assign o_resp.crc_rx   = shreg[7:1];
    assign o_resp.crc_calc = crc;
    assign o_stat.state    = state;
    assign o_stat.err      = err;
    assign o_stat.busy     = (state != CMD_IDLE);

endmodule

// ==== src/sd_ctrl_top.sv ====
//####################################################################
// sd host controller front end top level
// wishbone register block plus cmd line engine
//####################################################################
`timescale 1ns/1ps

module sd_ctrl_top import sd_pkg::*; #(
    parameter logic [15:0] WDOG_RESET    = 16'h0400,
    parameter logic [7:0]  SCK_DIV_RESET = 8'd4
) (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_wb_cyc,
    input  logic       i_wb_stb,
    input  logic       i_wb_we,
    input  wb_addr_t   i_wb_adr,
    input  wb_data_t   i_wb_dat,
    output logic       o_wb_ack,
    output wb_data_t   o_wb_dat,
    input  logic       i_sd_cmd,
    input  logic [3:0] i_sd_dat,
    output logic       o_sd_clk,
    output logic       o_sd_cmd,
    output logic       o_sd_cmd_oe   // 1: host drives cmd
);

    sd_sck_t      sck;
    sd_cmd_req_t  cmd_req;
    sd_cmd_resp_t cmd_resp;
    sd_cmd_stat_t cmd_stat;
    logic [15:0]  watchdog;
    logic         clear_err;

    sd_regs #(
        .WDOG_RESET    (WDOG_RESET),
        .SCK_DIV_RESET (SCK_DIV_RESET)
    ) u_regs (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_adr    (i_wb_adr),
        .i_wb_dat    (i_wb_dat),
        .i_sd_cmd    (i_sd_cmd),
        .i_sd_dat    (i_sd_dat),
        .i_resp      (cmd_resp),
        .i_stat      (cmd_stat),
        .o_wb_ack    (o_wb_ack),
        .o_wb_dat    (o_wb_dat),
        .o_sck       (sck),
        .o_req       (cmd_req),
        .o_watchdog  (watchdog),
        .o_clear_err (clear_err)
    );

    sd_cmd_ctrl u_cmd (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_sck       (sck),
        .i_req       (cmd_req),
        .i_watchdog  (watchdog),
        .i_clear_err (clear_err),
        .i_sd_cmd    (i_sd_cmd),
        .o_sd_cmd    (o_sd_cmd),
        .o_sd_cmd_oe (o_sd_cmd_oe),
        .o_resp      (cmd_resp),
        .o_stat      (cmd_stat)
    );

    assign o_sd_clk = sck.level;  // scaler level goes straight to the pad

endmodule

// ==== tb/sd_ctrl_asserts.sv ====
//####################################################################
// concurrent assertions bound to the sd controller top level
// wishbone ack protocol, cmd output enable in idle
//####################################################################
`timescale 1ns/1ps

module sd_ctrl_asserts import sd_pkg::*; (
    input logic          i_clk,
    input logic          i_nrst,
    input logic          i_wb_cyc,
    input logic          i_wb_stb,
    input logic          i_wb_ack,
    input logic          i_sd_cmd_oe,
    input sd_cmd_state_e i_state
);

    ack_in_cycle: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_wb_ack |-> (i_wb_cyc && i_wb_stb))
        else $error("ack outside a bus cycle");

    ack_single: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_wb_ack |=> !i_wb_ack)  // one cycle per access
        else $error("ack held for two cycles");

    oe_idle: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_state == CMD_IDLE) |-> !i_sd_cmd_oe)
        else $error("cmd driven while engine idle");

endmodule

// ==== tb/sd_ctrl_tb.sv ====
//####################################################################
// testbench for the sd host controller front end
// clock, reset, wishbone bus tasks, sd card model on cmd line,
// crc7 reference model and register, clock and command checks
//####################################################################
`timescale 1ns/1ps

module sd_ctrl_tb import sd_pkg::*; ();

    logic       clk;
    logic       nrst;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_addr_t   wb_adr;
    wb_data_t   wb_wdat;
    logic       wb_ack;
    wb_data_t   wb_rdat;
    logic       sd_cmd_in;     // card side of the cmd line
    logic [3:0] sd_dat;
    logic       sd_clk;
    logic       sd_cmd_out;
    logic       sd_cmd_oe;

    integer seed = 32'h1d2881f0;
    int     errors;
    int     test_errs;
    int     tests;

    sd_ctrl_top i_sd_ctrl_top (
        .i_clk       (clk),
        .i_nrst      (nrst),
        .i_wb_cyc    (wb_cyc),
        .i_wb_stb    (wb_stb),
        .i_wb_we     (wb_we),
        .i_wb_adr    (wb_adr),
        .i_wb_dat    (wb_wdat),
        .o_wb_ack    (wb_ack),
        .o_wb_dat    (wb_rdat),
        .i_sd_cmd    (sd_cmd_in),
        .i_sd_dat    (sd_dat),
        .o_sd_clk    (sd_clk),
        .o_sd_cmd    (sd_cmd_out),
        .o_sd_cmd_oe (sd_cmd_oe)
    );

    always #20 clk = ~clk;  // 40 ns period

    // crc7 x^7 + x^3 + 1 over 40 bits, msb first
    function automatic sd_crc7_t calc_crc7(input logic [39:0] bits);
        sd_crc7_t c;
        logic     inv;
        c = '0;
        for (int i = 39; i >= 0; i--) begin
            inv = bits[i] ^ c[6];
            c   = {c[5:0], 1'b0};
            if (inv) c = c ^ 7'h09;
        end
        return c;
    endfunction

    function automatic logic [47:0] build_frame(input logic dir, input sd_cmd_idx_t idx,
                                                input sd_arg_t arg);
        logic [39:0] head;
        head = {1'b0, dir, idx, arg};
        return {head, calc_crc7(head), 1'b1};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
            test_errs++;
        end
    endtask

    task automatic bus_access(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                              output wb_data_t rdat);
        int n;
        @(negedge clk);
        wb_cyc  = 1'b1;
        wb_stb  = 1'b1;
        wb_we   = we;
        wb_adr  = adr;
        wb_wdat = wdat;
        n = 0;
        @(negedge clk);
        while (!wb_ack && n < 100) begin  // bounded wait for ack
            n++;
            @(negedge clk);
        end
        if (!wb_ack) begin
            $display("bus access to offset %h was never acknowledged", adr);
            test_errs++;
        end
        rdat = wb_rdat;
        @(negedge clk);  // cycle ends after the edge that samples ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_reg(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t dummy;
        bus_access(1'b1, adr, dat, dummy);
    endtask

    task automatic read_check(input wb_addr_t adr, input wb_data_t exp, input string name);
        wb_data_t got;
        bus_access(1'b0, adr, '0, got);
        check_val(name, got, exp);
    endtask

    // waits for a rising (rise=1) or falling sd clock edge
    task automatic wait_sck(input logic rise, output logic ok);
        logic prev;
        int   n;
        prev = sd_clk;
        ok   = 1'b0;
        n    = 0;
        while (!ok && n < 4000) begin
            @(posedge clk);
            #1;
            if (sd_clk == rise && prev != rise) ok = 1'b1;
            prev = sd_clk;
            n++;
        end
        if (!ok) begin
            $display("sd clock edge did not arrive in time");
            test_errs++;
        end
    endtask

    // card: mode 0 good, 1 bad crc, 2 zero end bit, 3 silent
    task automatic card_model(input int mode, input int delay, input sd_cmd_idx_t ridx,
                              input sd_arg_t rarg, output logic [47:0] frame);
        logic        ok;
        logic        found;
        logic [47:0] resp;
        int          n;
        frame = '0;
        found = 1'b0;
        n     = 0;
        while (!found && n < 200) begin  // look for first driven bit
            wait_sck(1'b1, ok);
            if (ok && sd_cmd_oe) found = 1'b1;
            n++;
        end
        if (!found) begin
            $display("card model saw no command frame");
            test_errs++;
            return;
        end
        frame[47] = sd_cmd_out;
        for (int i = 46; i >= 0; i--) begin
            wait_sck(1'b1, ok);
            frame[i] = sd_cmd_out;
        end
        if (mode == 3) return;  // stay silent
        resp = build_frame(1'b0, ridx, rarg);
        if (mode == 1) resp[1] = ~resp[1];
        if (mode == 2) resp[0] = 1'b0;
        repeat (delay) wait_sck(1'b0, ok);
        for (int i = 47; i >= 0; i--) begin
            wait_sck(1'b0, ok);
            check_val("sd_cmd_oe", {31'd0, sd_cmd_oe}, 32'd0);  // host released the line
            @(negedge clk);
            sd_cmd_in = resp[i];
        end
        wait_sck(1'b0, ok);
        @(negedge clk);
        sd_cmd_in = 1'b1;  // pull-up again
    endtask

    task automatic wait_idle(output wb_data_t stat);
        int n;
        n = 0;
        bus_access(1'b0, REG_STATUS, '0, stat);
        while (stat[8] && n < 2000) begin
            n++;
            bus_access(1'b0, REG_STATUS, '0, stat);
        end
        if (stat[8]) begin
            $display("command engine stayed busy");
            test_errs++;
        end
    endtask

    task automatic run_cmd(input int mode, input sd_cmd_idx_t idx, input sd_arg_t arg,
                           input sd_arg_t rarg, output logic [47:0] frame,
                           output wb_data_t stat);
        int delay;
        delay = $unsigned($random(seed)) % 4;
        write_reg(REG_CMD_ARG, arg);
        fork
            write_reg(REG_CMD_START, {26'd0, idx});
            card_model(mode, delay, idx, rarg, frame);
        join
        wait_idle(stat);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errs == 0) $display("test %0d %s: passed", tests, name);
        else $display("test %0d %s: failed with %0d errors", tests, name, test_errs);
        errors   += test_errs;
        test_errs = 0;
    endtask

    task automatic measure_period(output int cycles);
        logic ok;
        time  t0;
        wait_sck(1'b1, ok);
        t0 = $time;
        wait_sck(1'b1, ok);
        cycles = int'(($time - t0) / 40);
    endtask

    initial begin
        wb_data_t    v;
        wb_data_t    stat;
        logic [7:0]  ddiv;
        logic [23:0] idiv;
        int          per;
        sd_cmd_idx_t idx;
        sd_arg_t     arg;
        sd_arg_t     rarg;
        logic [47:0] frame;
        logic [47:0] exp_frame;
        sd_crc7_t    crc;
        clk       = 1'b0;
        nrst      = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_wdat   = '0;
        sd_cmd_in = 1'b1;
        sd_dat    = 4'hF;
        errors    = 0;
        test_errs = 0;
        tests     = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;

        v = $random(seed);
        write_reg(REG_SCKDIV, v);
        read_check(REG_SCKDIV, v, "sckdiv");
        v = $random(seed);
        write_reg(REG_WATCHDOG, v);
        read_check(REG_WATCHDOG, {16'd0, v[15:0]}, "watchdog");
        v = $random(seed);
        write_reg(REG_CMD_ARG, v);
        read_check(REG_CMD_ARG, v, "cmd_arg");
        read_check(REG_CONTROL, 32'h0000_01F0, "control");  // cmd pin high, dat 0xf
        write_reg(REG_STATUS, 32'hFFFF_FFFF);
        read_check(REG_STATUS, 32'h0, "status");
        read_check(REG_CMD_START, 32'h0, "cmd_start");
        write_reg(8'h20, $random(seed));
        read_check(8'h20, 32'h0, "unmapped_20");
        write_reg(8'hFC, $random(seed));
        read_check(8'hFC, 32'h0, "unmapped_fc");
        end_test("register access");

        ddiv = 8'($unsigned($random(seed)) % 8);
        idiv = 24'(ddiv) + 24'd1 + 24'($unsigned($random(seed)) % 8);  // always above ddiv
        write_reg(REG_CONTROL, 32'h1);
        write_reg(REG_SCKDIV, {ddiv, idiv});
        measure_period(per);
        check_val("sck_period_data", per, 2 * (ddiv + 1));
        write_reg(REG_CONTROL, 32'h5);
        write_reg(REG_SCKDIV, {ddiv, idiv});  // restart count for the new compare
        measure_period(per);
        check_val("sck_period_ident", per, 2 * (idiv + 1));
        write_reg(REG_CONTROL, 32'h1);
        write_reg(REG_SCKDIV, {ddiv, idiv});
        end_test("sd clock scaler");

        write_reg(REG_WATCHDOG, 32'd64);
        idx  = 6'($random(seed));
        arg  = $random(seed);
        rarg = $random(seed);
        run_cmd(0, idx, arg, rarg, frame, stat);
        exp_frame = build_frame(1'b1, idx, arg);
        check_val("cmd_frame_hi", {16'd0, frame[47:32]}, {16'd0, exp_frame[47:32]});
        check_val("cmd_frame_lo", frame[31:0], exp_frame[31:0]);
        end_test("command frame");

        idx  = 6'($random(seed));
        arg  = $random(seed);
        rarg = $random(seed);
        crc  = calc_crc7({2'b00, idx, rarg});
        run_cmd(0, idx, arg, rarg, frame, stat);
        check_val("status", stat, 32'h0);
        read_check(REG_LAST_RESP, {1'b0, crc, 1'b0, crc, 2'b0, idx, 2'b0, idx}, "last_resp");
        read_check(REG_RESP_ARG, rarg, "resp_arg");
        end_test("r1 response");

        run_cmd(1, 6'($random(seed)), $random(seed), $random(seed), frame, stat);
        check_val("status_crc", stat, {28'd0, SD_ERR_CRC});
        write_reg(REG_CONTROL, 32'h3);
        read_check(REG_STATUS, 32'h0, "status_cleared");
        run_cmd(2, 6'($random(seed)), $random(seed), $random(seed), frame, stat);
        check_val("status_stop", stat, {28'd0, SD_ERR_STOP});
        write_reg(REG_CONTROL, 32'h3);
        read_check(REG_STATUS, 32'h0, "status_cleared");
        run_cmd(3, 6'($random(seed)), $random(seed), $random(seed), frame, stat);
        check_val("status_timeout", stat, {28'd0, SD_ERR_TIMEOUT});
        write_reg(REG_CONTROL, 32'h3);
        read_check(REG_STATUS, 32'h0, "status_cleared");
        end_test("error codes");

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

bind sd_ctrl_top sd_ctrl_asserts u_asserts (
    .i_clk       (i_clk),
    .i_nrst      (i_nrst),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_ack    (o_wb_ack),
    .i_sd_cmd_oe (o_sd_cmd_oe),
    .i_state     (cmd_stat.state)
);

// ==== verilog.f ====
src/sd_pkg.sv
src/sd_regs.sv
src/sd_cmd_ctrl.sv
src/sd_ctrl_top.sv
tb/sd_ctrl_asserts.sv
tb/sd_ctrl_tb.sv

// ==== Makefile ====
# Verilator build and run for the sd controller testbench

VERILATOR ?= verilator
TOP       ?= sd_ctrl_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(wildcard src/*.sv tb/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) verilog.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f verilog.f

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
